// ==== src/mxq_consts.svh ====
`ifndef MXQ_CONSTS_SVH
`define MXQ_CONSTS_SVH

`define MXQ_IN_W    16  // Input sample width
`define MXQ_MAN_W   8   // Signed mantissa width
`define MXQ_EXP_W   8   // Shared exponent width
`define MXQ_BLOCK   6   // Samples per block

// Any 16-bit sample fits an 8-bit mantissa after this shift
`define MXQ_MAX_EXP (`MXQ_IN_W - `MXQ_MAN_W)

`endif

// ==== src/mxq_pkg.sv ====
`include "mxq_consts.svh"

package mxq_pkg;

  typedef logic signed [`MXQ_IN_W-1:0]  sample_t;  // Raw input sample
  typedef logic signed [`MXQ_MAN_W-1:0] man_t;     // Quantized mantissa
  typedef logic [`MXQ_EXP_W-1:0]        exp_t;     // Shared block exponent
  typedef logic [2:0]                   idx_t;     // Position inside a block

  // Block controller states
  typedef enum logic [1:0] {
    COLLECT,  // Taking samples
    QUANT,    // One cycle to register the quantized block
    EMIT      // Waiting for the block to leave
  } ctrl_state_t;

endpackage

// ==== src/mxq_block_if.sv ====
`timescale 1ns/1ps
`include "mxq_consts.svh"

interface mxq_block_if
  import mxq_pkg::*;
();

  man_t man [`MXQ_BLOCK];  // Mantissas of one block
  exp_t exp;               // Shared exponent
  logic valid;
  logic ready;

  modport src (
    output man,
    output exp,
    output valid,
    input  ready
  );

  modport dst (
    input  man,
    input  exp,
    input  valid,
    output ready
  );

endinterface

// ==== src/mxq_elem_counter.sv ====
`timescale 1ns/1ps
`include "mxq_consts.svh"

module mxq_elem_counter
  import mxq_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic accept,
  output idx_t idx,
  output logic last
);

  localparam idx_t LAST_IDX = idx_t'(`MXQ_BLOCK - 1);

  assign last = (idx == LAST_IDX);  // Final sample slot of the block

  always_ff @(posedge clk) begin
    if (rst) begin
      idx <= '0;
    end else if (accept) begin
      if (last) begin
        idx <= '0;  // Start the next block
      end else begin
        idx <= idx + idx_t'(1);
      end
    end
  end

endmodule

// ==== src/mxq_ctrl_fsm.sv ====
`timescale 1ns/1ps

module mxq_ctrl_fsm
  import mxq_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid,
  input  logic        last,
  input  logic        blk_fire,
  output logic        in_ready,
  output logic        accept,
  output logic        quant,
  output ctrl_state_t state
);

  ctrl_state_t state_next;

  assign in_ready = (state == COLLECT);  // Input only open while collecting
  assign accept   = in_valid && in_ready;
  assign quant    = (state == QUANT);    // Single-cycle strobe

  always_comb begin
    state_next = state;
    case (state)
      COLLECT: begin
        if (accept && last) begin
          state_next = QUANT;  // Sixth sample taken
        end
      end
      QUANT: begin
        state_next = EMIT;
      end
      EMIT: begin
        if (blk_fire) begin
          state_next = COLLECT;  // Block handed to the output slice
        end
      end
      default: begin
        state_next = COLLECT;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= COLLECT;
    end else begin
      state <= state_next;
    end
  end

endmodule

// ==== src/mxq_block_buffer.sv ====
`timescale 1ns/1ps
`include "mxq_consts.svh"

module mxq_block_buffer
  import mxq_pkg::*;
(
  input  logic    clk,
  input  logic    accept,
  input  idx_t    idx,
  input  sample_t in_data,
  output sample_t samples [`MXQ_BLOCK]
);

  // Write-addressed storage, one entry per block position.
  // Input is closed during QUANT and EMIT, so the block stays put
  // while it is being quantized.
  always_ff @(posedge clk) begin
    if (accept) begin
      samples[idx] <= in_data;
    end
  end

endmodule

// ==== src/mxq_exp_shift.sv ====
`timescale 1ns/1ps
`include "mxq_consts.svh"

module mxq_exp_shift
  import mxq_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     quant,
  input  sample_t  samples [`MXQ_BLOCK],
  mxq_block_if.src blk
);

  localparam int MAN_MAX = (1 << (`MXQ_MAN_W - 1)) - 1;
  localparam int MAN_MIN = -(1 << (`MXQ_MAN_W - 1));

  exp_t shift_need [`MXQ_BLOCK];  // Per-sample minimum shift
  exp_t blk_exp;                  // Largest shift over the block
  man_t man_next   [`MXQ_BLOCK];

  // Smallest right shift that brings s into the mantissa range
  function automatic exp_t min_shift(sample_t s);
    exp_t    e;
    sample_t t;
    e = exp_t'(`MXQ_MAX_EXP);
    for (int k = `MXQ_MAX_EXP; k >= 0; k--) begin
      t = s >>> k;  // Floor toward minus infinity
      if (t >= MAN_MIN && t <= MAN_MAX) begin
        e = exp_t'(k);  // Keeps the smallest one that fits
      end
    end
    return e;
  endfunction

  always_comb begin
    blk_exp = '0;
    for (int i = 0; i < `MXQ_BLOCK; i++) begin
      shift_need[i] = min_shift(samples[i]);
      if (shift_need[i] > blk_exp) begin
        blk_exp = shift_need[i];
      end
    end
    for (int i = 0; i < `MXQ_BLOCK; i++) begin
      man_next[i] = man_t'(samples[i] >>> blk_exp);  // Upper bits are sign copies
    end
  end

  // Payload captured on the edge leaving QUANT
  always_ff @(posedge clk) begin
    if (quant) begin
      blk.man <= man_next;
      blk.exp <= blk_exp;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      blk.valid <= 1'b0;
    end else if (quant) begin
      blk.valid <= 1'b1;
    end else if (blk.valid && blk.ready) begin
      blk.valid <= 1'b0;  // Block taken by the slice
    end
  end

endmodule

// ==== src/mxint_register_slice.sv ====
`timescale 1ns/1ps

module mxint_register_slice
  import mxq_pkg::*;
#(
  parameter int DATA_PRECISION_0 = 8,  // Mantissa width
  parameter int DATA_PRECISION_1 = 8,  // Exponent width
  parameter int IN_NUM           = 6   // Mantissas per block
) (
  input  logic     clk,
  input  logic     rst,
  mxq_block_if.dst blk,
  output man_t     mdata_out [IN_NUM],
  output exp_t     edata_out,
  output logic     data_out_valid,
  input  logic     data_out_ready
);

  localparam int LANE_W  = DATA_PRECISION_0;
  localparam int E_LANES = (DATA_PRECISION_1 + LANE_W - 1) / LANE_W;  // Exponent pieces
  localparam int LANES   = IN_NUM + E_LANES;
  localparam int EXT_W   = E_LANES * LANE_W;

  logic [LANE_W-1:0] lane_in [LANES];  // Mantissas then exponent pieces
  logic [LANE_W-1:0] main_q  [LANES];  // Output entry
  logic [LANE_W-1:0] skid_q  [LANES];  // Overflow entry
  logic [EXT_W-1:0]  exp_ext_in;
  logic [EXT_W-1:0]  exp_ext_out;
  logic              main_valid;
  logic              skid_valid;
  logic              in_fire;
  logic              main_load;

  assign exp_ext_in = EXT_W'(blk.exp);  // Zero-filled above the exponent

  for (genvar i = 0; i < IN_NUM; i++) begin : g_man
    assign lane_in[i]   = blk.man[i];
    assign mdata_out[i] = main_q[i];
  end

  for (genvar j = 0; j < E_LANES; j++) begin : g_exp
    assign lane_in[IN_NUM + j]           = exp_ext_in[j*LANE_W +: LANE_W];
    assign exp_ext_out[j*LANE_W +: LANE_W] = main_q[IN_NUM + j];
  end

  assign edata_out = exp_ext_out[DATA_PRECISION_1-1:0];

  // Ready comes from a register, so it never depends on data_out_ready
  assign blk.ready      = !skid_valid;
  assign in_fire        = blk.valid && blk.ready;
  assign main_load      = !main_valid || data_out_ready;  // Output entry can take new data
  assign data_out_valid = main_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      if (skid_valid) begin
        main_valid <= 1'b1;  // Drain the skid entry first
        skid_valid <= 1'b0;
      end else begin
        main_valid <= in_fire;
      end
    end else if (in_fire) begin
      skid_valid <= 1'b1;  // Output stalled, park the block
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      if (skid_valid) begin
        main_q <= skid_q;
      end else if (in_fire) begin
        main_q <= lane_in;
      end
    end else if (in_fire) begin
      skid_q <= lane_in;
    end
  end

endmodule

// ==== src/mxq_top.sv ====
`timescale 1ns/1ps
`include "mxq_consts.svh"

module mxq_top
  import mxq_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  sample_t in_data,
  input  logic    in_valid,
  output logic    in_ready,
  output man_t    out_mant [`MXQ_BLOCK],
  output exp_t    out_exp,
  output logic    out_valid,
  input  logic    out_ready
);

  logic        accept;
  logic        last;
  logic        quant;
  logic        blk_fire;
  idx_t        idx;
  sample_t     samples [`MXQ_BLOCK];

  mxq_block_if blk_if ();

  assign blk_fire = blk_if.valid && blk_if.ready;

  mxq_elem_counter u_elem_counter (
    .clk    (clk),
    .rst    (rst),
    .accept (accept),
    .idx    (idx),
    .last   (last)
  );

  mxq_ctrl_fsm u_ctrl_fsm (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .last     (last),
    .blk_fire (blk_fire),
    .in_ready (in_ready),
    .accept   (accept),
    .quant    (quant),
    .state    ()
  );

  mxq_block_buffer u_block_buffer (
    .clk     (clk),
    .accept  (accept),
    .idx     (idx),
    .in_data (in_data),
    .samples (samples)
  );

  mxq_exp_shift u_exp_shift (
    .clk     (clk),
    .rst     (rst),
    .quant   (quant),
    .samples (samples),
    .blk     (blk_if.src)
  );

  mxint_register_slice #(
    .DATA_PRECISION_0 (`MXQ_MAN_W),
    .DATA_PRECISION_1 (`MXQ_EXP_W),
    .IN_NUM           (`MXQ_BLOCK)
  ) u_out_slice (
    .clk            (clk),
    .rst            (rst),
    .blk            (blk_if.dst),
    .mdata_out      (out_mant),
    .edata_out      (out_exp),
    .data_out_valid (out_valid),
    .data_out_ready (out_ready)
  );

endmodule

// ==== sim/mxq_chk.sv ====
`timescale 1ns/1ps
`include "mxq_consts.svh"

module mxq_chk
  import mxq_pkg::*;
(
  input logic clk,
  input logic rst,
  input logic out_valid,
  input logic out_ready,
  input exp_t out_exp,
  input man_t out_mant [`MXQ_BLOCK]
);

  logic [`MXQ_BLOCK*`MXQ_MAN_W-1:0] mant_flat;  // Packed view of the mantissas
  int fail_count = 0;

  always_comb begin
    for (int i = 0; i < `MXQ_BLOCK; i++) begin
      mant_flat[i*`MXQ_MAN_W +: `MXQ_MAN_W] = out_mant[i];
    end
  end

  a_reset_clear: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
      fail_count++;
      $error("out_valid high after a reset cycle");
    end

  // Stalled output holds its block
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_exp) && $stable(mant_flat))
    else begin
      fail_count++;
      $error("Output changed while stalled");
    end

  a_exp_range: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> out_exp <= exp_t'(`MXQ_MAX_EXP))
    else begin
      fail_count++;
      $error("Exponent above the largest legal value");
    end

endmodule

bind mxq_top mxq_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_exp   (out_exp),
  .out_mant  (out_mant)
);

// ==== sim/mxq_tb.sv ====
`timescale 1ns/1ps
`include "mxq_consts.svh"

module mxq_tb
  import mxq_pkg::*;
();

  localparam int MODE_FULL    = 0;  // Any 16-bit value
  localparam int MODE_SMALL   = 1;  // Already inside the mantissa range
  localparam int MODE_EXTREME = 2;  // Block opens with -32768 or 32767
  localparam int MODE_ONEBIT  = 3;  // 9-bit values, first one odd and negative

  localparam int BLK_FULL    = 20;
  localparam int BLK_SMALL   = 10;
  localparam int BLK_EXTREME = 8;
  localparam int BLK_ONEBIT  = 8;
  localparam int BLK_STALL   = 20;
  localparam int BLK_HEAVY   = 12;
  localparam int TOTAL_BLOCKS =
    BLK_FULL + BLK_SMALL + BLK_EXTREME + BLK_ONEBIT + BLK_STALL + BLK_HEAVY;
  localparam int TOTAL_SAMPLES = TOTAL_BLOCKS * `MXQ_BLOCK;
  localparam int CYCLE_LIMIT   = TOTAL_SAMPLES * 8 + 2000;

  localparam int MAN_HI = (1 << (`MXQ_MAN_W - 1)) - 1;
  localparam int MAN_LO = -(1 << (`MXQ_MAN_W - 1));

  logic    clk;
  logic    rst;
  sample_t in_data;
  logic    in_valid;
  logic    in_ready;
  man_t    out_mant [`MXQ_BLOCK];
  exp_t    out_exp;
  logic    out_valid;
  logic    out_ready;

  integer  seed;
  int      errors = 0;
  int      blocks_in = 0;
  int      blocks_out = 0;
  int      cycles;
  sample_t in_q  [$];  // Accepted samples of the open block
  exp_t    exp_q [$];  // Expected exponents, oldest first
  man_t    man_q [$];  // Expected mantissas, six per block

  mxq_top u_mxq_top (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_mant  (out_mant),
    .out_exp   (out_exp),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic bit chance(int pct);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return (r % 100) < pct;
  endfunction

  function automatic sample_t gen_sample(int mode, int pos);
    sample_t r;
    r = sample_t'($random(seed));
    case (mode)
      MODE_SMALL:   return {{8{r[7]}}, r[7:0]};
      MODE_EXTREME: return (pos == 0) ? (r[0] ? 16'sh7fff : 16'sh8000) : r;
      MODE_ONEBIT: begin
        if (pos == 0) begin
          return sample_t'(-129 - 2 * int'(r[13:8]));  // Odd, from -129 down to -255
        end
        return {{7{r[8]}}, r[8:0]};
      end
      default:      return r;
    endcase
  endfunction

  // Smallest exponent for which every shifted sample fits the mantissa
  function automatic exp_t block_exponent();
    int v;
    bit fits;
    for (int e = 0; e <= `MXQ_MAX_EXP; e++) begin
      fits = 1'b1;
      for (int i = 0; i < `MXQ_BLOCK; i++) begin
        v = int'(in_q[i]) >>> e;
        if (v < MAN_LO || v > MAN_HI) fits = 1'b0;
      end
      if (fits) return exp_t'(e);
    end
    return exp_t'(`MXQ_MAX_EXP);
  endfunction

  task automatic model_block();
    exp_t e;
    e = block_exponent();
    exp_q.push_back(e);
    for (int i = 0; i < `MXQ_BLOCK; i++) begin
      man_q.push_back(man_t'(int'(in_q[i]) >>> e));  // Floors toward minus infinity
    end
    repeat (`MXQ_BLOCK) void'(in_q.pop_front());
    blocks_in++;
  endtask

  task automatic check_exp(int blk_no, exp_t want, exp_t got);
    if (got !== want) begin
      $display("ERR %0t: block %0d exponent expected %0d got %0d", $time, blk_no, want, got);
      errors++;
    end
  endtask

  task automatic check_mant(int blk_no, int lane, man_t want, man_t got);
    if (got !== want) begin
      $display("ERR %0t: block %0d lane %0d mantissa expected %0d got %0d",
               $time, blk_no, lane, want, got);
      errors++;
    end
  endtask

  task automatic check_block();
    if (exp_q.size() == 0) begin
      $display("Output block %0d came out with no block expected", blocks_out);
      errors++;
    end else begin
      check_exp(blocks_out, exp_q.pop_front(), out_exp);
      for (int i = 0; i < `MXQ_BLOCK; i++) begin
        check_mant(blocks_out, i, man_q.pop_front(), out_mant[i]);
      end
    end
    blocks_out++;
  endtask

  // Handshakes are stable at the falling edge
  always @(negedge clk) begin
    if (!rst && in_valid && in_ready) begin
      in_q.push_back(in_data);
      if (in_q.size() == `MXQ_BLOCK) model_block();
    end
    if (!rst && out_valid && out_ready) check_block();
  end

  task automatic run_phase(int n_blocks, int mode, int gap_pct, int stall_pct);
    int sent;
    bit taken;
    sent = 0;
    while (sent < n_blocks * `MXQ_BLOCK) begin
      out_ready = !chance(stall_pct);
      if (!in_valid && !chance(gap_pct)) begin
        in_data  = gen_sample(mode, sent % `MXQ_BLOCK);
        in_valid = 1'b1;
      end
      @(negedge clk);
      taken = in_valid && in_ready;
      @(posedge clk);
      #1;
      if (taken) begin
        sent++;
        in_valid = 1'b0;
      end
    end
  endtask

  task automatic finish_run();
    if (exp_q.size() > 0) begin
      $display("Missing blocks: %0d expected blocks never came out", exp_q.size());
      errors += exp_q.size();
    end
    errors += u_mxq_top.u_chk.fail_count;  // Assertion failures
    $display("Errors: %0d, blocks checked: %0d of %0d", errors, blocks_out, blocks_in);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  initial begin
    seed      = 24470;
    rst       = 1'b1;
    in_data   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    run_phase(BLK_FULL,    MODE_FULL,    0,  0);
    run_phase(BLK_SMALL,   MODE_SMALL,   10, 0);
    run_phase(BLK_EXTREME, MODE_EXTREME, 0,  10);
    run_phase(BLK_ONEBIT,  MODE_ONEBIT,  10, 10);
    run_phase(BLK_STALL,   MODE_FULL,    30, 40);  // Gaps mid-block and stalls
    run_phase(BLK_HEAVY,   MODE_FULL,    0,  70);  // Keeps the skid entry busy
    out_ready = 1'b1;
    while (blocks_out < TOTAL_BLOCKS) @(posedge clk);
    repeat (4) @(posedge clk);
    finish_run();
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run stopped after %0d cycles before all blocks came out", cycles);
    errors++;
    finish_run();
  end

endmodule

// ==== sim.f ====
+incdir+src
src/mxq_pkg.sv
src/mxq_block_if.sv
src/mxq_elem_counter.sv
src/mxq_ctrl_fsm.sv
src/mxq_block_buffer.sv
src/mxq_exp_shift.sv
src/mxint_register_slice.sv
src/mxq_top.sv
sim/mxq_chk.sv
sim/mxq_tb.sv
